//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fetch_tb -f vlog.f -o fetch_sim
	./obj_dir/fetch_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bpred/bpred_table.sv
`timescale 1ns/1ns

module bpred_table (
    input  logic             clk,
    input  logic             reset,
    // Lookup on the current fetch PC
    input  fetch_pkg::addr_t lookup_pc,
    output logic             pred_hit,
    output logic             pred_taken,
    output fetch_pkg::addr_t pred_target,
    // Training from the resolution unit
    input  logic             train_valid,
    input  logic             train_taken,
    input  fetch_pkg::addr_t train_pc,
    input  fetch_pkg::addr_t train_target
);

    // Per-slot storage
    logic [fetch_pkg::TAG_W-1:0] tag_mem    [fetch_pkg::TABLE_SIZE];
    fetch_pkg::addr_t            target_mem [fetch_pkg::TABLE_SIZE];
    fetch_pkg::ctr_t             ctr_mem    [fetch_pkg::TABLE_SIZE];
    logic                        valid_mem  [fetch_pkg::TABLE_SIZE];

    logic [fetch_pkg::INDEX_BITS-1:0] lookup_idx;
    logic [fetch_pkg::TAG_W-1:0]      lookup_tag;
    logic [fetch_pkg::INDEX_BITS-1:0] train_idx;
    logic [fetch_pkg::TAG_W-1:0]      train_tag;
    logic                             train_same;

    // Saturating step of a direction counter
    function automatic fetch_pkg::ctr_t ctr_step(
        input fetch_pkg::ctr_t ctr,
        input logic            taken
    );
        if (taken) begin
            if (ctr == fetch_pkg::CTR_STRONG_T) begin
                return ctr;
            end
            return fetch_pkg::ctr_t'(ctr + 2'd1);
        end
        if (ctr == fetch_pkg::CTR_STRONG_NT) begin
            return ctr;
        end
        return fetch_pkg::ctr_t'(ctr - 2'd1);
    endfunction

    // Word address modulo table size picks the slot
    assign lookup_idx = lookup_pc[fetch_pkg::INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc[fetch_pkg::ADDR_W-1:2];
    assign train_idx  = train_pc[fetch_pkg::INDEX_BITS+1:2];
    assign train_tag  = train_pc[fetch_pkg::ADDR_W-1:2];

    // Same branch already owns the slot
    assign train_same = valid_mem[train_idx] && (tag_mem[train_idx] == train_tag);

    // Combinational lookup
    always_comb begin
        pred_hit    = valid_mem[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
        pred_taken  = pred_hit && (ctr_mem[lookup_idx] >= fetch_pkg::CTR_WEAK_T);
        pred_target = target_mem[lookup_idx];
    end

    // Valid bits and counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < fetch_pkg::TABLE_SIZE; i++) begin
                valid_mem[i] <= 1'b0;
                ctr_mem[i]   <= fetch_pkg::CTR_WEAK_NT;
            end
        end else if (train_valid) begin
            valid_mem[train_idx] <= 1'b1;
            if (train_same) begin
                ctr_mem[train_idx] <= ctr_step(ctr_mem[train_idx], train_taken);
            end else begin
                // New owner starts from the weak state of its first outcome
                ctr_mem[train_idx] <= train_taken ? fetch_pkg::CTR_WEAK_T
                                                  : fetch_pkg::CTR_WEAK_NT;
            end
        end
    end

    // Tags and targets, rewritten on every training
    always_ff @(posedge clk) begin
        if (train_valid) begin
            tag_mem[train_idx]    <= train_tag;
            target_mem[train_idx] <= train_target;
        end
    end

endmodule

//--- common/fetch_pkg.sv
package fetch_pkg;

    // Address and table geometry
    localparam int ADDR_W     = 32;
    localparam int INDEX_BITS = 4;
    localparam int TABLE_SIZE = 2 ** INDEX_BITS;

    // Tag is the whole word address, bits [31:2]
    localparam int TAG_W = ADDR_W - 2;

    // Entries buffered between fetch and decode
    localparam int QUEUE_DEPTH = 4;

    typedef logic [ADDR_W-1:0] addr_t;

    // First fetch address out of reset
    localparam addr_t RESET_PC = 32'h0000_1000;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_NT   = 2'd1;
    localparam ctr_t CTR_WEAK_T    = 2'd2;
    localparam ctr_t CTR_STRONG_T  = 2'd3;

    // One fetch request as it travels toward decode
    typedef struct packed {
        addr_t pc;
        logic  pred_taken;
        addr_t pred_next;
    } fetch_entry_t;

endpackage

//--- dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;

    // Cycle budget of each test
    localparam int BUDGET_RESET    = RESET_CYCLES + 40;
    localparam int BUDGET_STALL    = 240;
    localparam int BUDGET_TAKEN    = 80;
    localparam int BUDGET_MATCH    = 60;
    localparam int BUDGET_HYST     = 140;
    localparam int BUDGET_ALIAS    = 140;
    localparam int WATCHDOG_CYCLES = BUDGET_RESET + BUDGET_STALL + BUDGET_TAKEN
                                   + BUDGET_MATCH + BUDGET_HYST + BUDGET_ALIAS;

    logic             clk;
    logic             reset;
    logic             fetch_valid;
    logic             fetch_ready;
    fetch_pkg::addr_t fetch_pc;
    logic             fetch_pred_taken;
    fetch_pkg::addr_t fetch_pred_next;
    logic             resolve_valid;
    logic             resolve_taken;
    fetch_pkg::addr_t resolve_pc;
    fetch_pkg::addr_t resolve_target;
    fetch_pkg::addr_t resolve_pred_next;
    logic [15:0]      mispredict_count;

    // Reference predictor, word address kept per slot
    logic             m_valid  [fetch_pkg::TABLE_SIZE];
    fetch_pkg::addr_t m_word   [fetch_pkg::TABLE_SIZE];
    fetch_pkg::addr_t m_target [fetch_pkg::TABLE_SIZE];
    fetch_pkg::ctr_t  m_ctr    [fetch_pkg::TABLE_SIZE];

    fetch_pkg::addr_t exp_pc;
    logic [15:0]      exp_count;
    logic             first_taken;

    fetch_top u_fetch_top (
        .clk               (clk),
        .reset             (reset),
        .fetch_valid       (fetch_valid),
        .fetch_ready       (fetch_ready),
        .fetch_pc          (fetch_pc),
        .fetch_pred_taken  (fetch_pred_taken),
        .fetch_pred_next   (fetch_pred_next),
        .resolve_valid     (resolve_valid),
        .resolve_taken     (resolve_taken),
        .resolve_pc        (resolve_pc),
        .resolve_target    (resolve_target),
        .resolve_pred_next (resolve_pred_next),
        .mispredict_count  (mispredict_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t ns: %s = %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    function automatic int slot_of(input fetch_pkg::addr_t pc);
        return int'((pc >> 2) % fetch_pkg::TABLE_SIZE);
    endfunction

    function automatic logic model_taken(input fetch_pkg::addr_t pc);
        int idx;
        idx = slot_of(pc);
        return m_valid[idx] && (m_word[idx] == (pc >> 2))
               && (m_ctr[idx] >= fetch_pkg::CTR_WEAK_T);
    endfunction

    function automatic fetch_pkg::addr_t model_next(input fetch_pkg::addr_t pc);
        if (model_taken(pc)) begin
            return m_target[slot_of(pc)];
        end
        return pc + 32'd4;
    endfunction

    task automatic model_train(input fetch_pkg::addr_t pc, input logic taken,
                               input fetch_pkg::addr_t target);
        int idx;
        idx = slot_of(pc);
        if (m_valid[idx] && (m_word[idx] == (pc >> 2))) begin
            if (taken && (m_ctr[idx] != fetch_pkg::CTR_STRONG_T)) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end else if (!taken && (m_ctr[idx] != fetch_pkg::CTR_STRONG_NT)) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
        end else begin
            m_ctr[idx] = taken ? fetch_pkg::CTR_WEAK_T : fetch_pkg::CTR_WEAK_NT;
        end
        m_valid[idx]  = 1'b1;
        m_word[idx]   = pc >> 2;
        m_target[idx] = target;
    endtask

    // Pops n entries and follows the expected PC chain
    task automatic run_stream(input int n, input bit stalls);
        int               got;
        logic             ready;
        logic             held;
        fetch_pkg::addr_t held_pc;
        fetch_pkg::addr_t held_next;
        logic             held_taken;
        got = 0;
        held = 1'b0;
        held_pc = '0;
        held_next = '0;
        held_taken = 1'b0;
        while (got < n) begin
            @(negedge clk);
            if (held) begin
                check_bit("fetch_valid", fetch_valid, 1'b1);
                check_addr("fetch_pc", fetch_pc, held_pc);
                check_bit("fetch_pred_taken", fetch_pred_taken, held_taken);
                check_addr("fetch_pred_next", fetch_pred_next, held_next);
            end
            ready = stalls ? (($urandom % 3) != 0) : 1'b1;
            fetch_ready = ready;
            held = fetch_valid && !ready;
            held_pc = fetch_pc;
            held_next = fetch_pred_next;
            held_taken = fetch_pred_taken;
            if (fetch_valid && ready) begin
                check_addr("fetch_pc", fetch_pc, exp_pc);
                check_bit("fetch_pred_taken", fetch_pred_taken, model_taken(exp_pc));
                check_addr("fetch_pred_next", fetch_pred_next, model_next(exp_pc));
                if (got == 0) begin
                    first_taken = fetch_pred_taken;
                end
                exp_pc = model_next(exp_pc);
                got++;
            end
        end
        @(negedge clk);
        fetch_ready = 1'b0;
    endtask

    // One resolve pulse, carrying the prediction the stream gave
    task automatic resolve_branch(input fetch_pkg::addr_t pc, input logic taken,
                                  input fetch_pkg::addr_t target);
        fetch_pkg::addr_t pred_next;
        fetch_pkg::addr_t actual;
        int               waited;
        pred_next = model_next(pc);
        actual = taken ? target : pc + 32'd4;
        @(negedge clk);
        resolve_valid = 1'b1;
        resolve_taken = taken;
        resolve_pc = pc;
        resolve_target = target;
        resolve_pred_next = pred_next;
        @(negedge clk);
        resolve_valid = 1'b0;
        if (actual != pred_next) begin
            exp_count = exp_count + 16'd1;
            waited = 0;
            // Flush shows up as the queue going empty
            while (fetch_valid) begin
                @(negedge clk);
                waited++;
                if (waited > 4) begin
                    stop_on_error("Redirect did not flush the fetch queue in time");
                end
            end
            exp_pc = actual;
        end else begin
            @(negedge clk);
        end
        model_train(pc, taken, target);
        check_count("mispredict_count", mispredict_count, exp_count);
    endtask

    task automatic test_reset_stream();
        $display("Reset and sequential stream");
        check_bit("fetch_valid", fetch_valid, 1'b0);
        check_count("mispredict_count", mispredict_count, 16'd0);
        run_stream(12, 1'b0);
    endtask

    task automatic test_stall_stream();
        $display("Random fetch_ready stalls");
        run_stream(40, 1'b1);
    endtask

    task automatic test_taken_redirect();
        $display("Taken branch redirect and refetch");
        resolve_branch(32'h0000_1010, 1'b1, 32'h0000_1200);
        run_stream(6, 1'b0);
        // Branch at the end of the target block jumps back
        resolve_branch(32'h0000_1208, 1'b1, 32'h0000_1010);
        run_stream(8, 1'b0);
        check_bit("first fetch_pred_taken", first_taken, 1'b1);
    endtask

    task automatic test_matching_resolve();
        $display("Resolve that matches its prediction");
        resolve_branch(32'h0000_1010, 1'b1, 32'h0000_1200);
        run_stream(8, 1'b1);
    endtask

    task automatic test_counter_hysteresis();
        $display("Counter hysteresis");
        resolve_branch(32'h0000_1010, 1'b0, 32'h0000_1200);
        run_stream(4, 1'b0);
        resolve_branch(32'h0000_1100, 1'b1, 32'h0000_1010);
        run_stream(5, 1'b0);
        check_bit("first fetch_pred_taken", first_taken, 1'b1);
        resolve_branch(32'h0000_1010, 1'b0, 32'h0000_1200);
        run_stream(4, 1'b0);
        resolve_branch(32'h0000_1104, 1'b1, 32'h0000_1010);
        run_stream(5, 1'b0);
        check_bit("first fetch_pred_taken", first_taken, 1'b0);
    endtask

    task automatic test_slot_alias();
        $display("Two branches sharing one slot");
        resolve_branch(32'h0000_1020, 1'b1, 32'h0000_1400);
        run_stream(3, 1'b0);
        resolve_branch(32'h0000_1140, 1'b1, 32'h0000_1020);
        run_stream(3, 1'b0);
        check_bit("first fetch_pred_taken", first_taken, 1'b1);
        // 64 bytes further on, same slot
        resolve_branch(32'h0000_1060, 1'b1, 32'h0000_1500);
        run_stream(3, 1'b0);
        resolve_branch(32'h0000_1180, 1'b1, 32'h0000_1020);
        run_stream(3, 1'b0);
        check_bit("first fetch_pred_taken", first_taken, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h8c19));
        reset = 1'b1;
        fetch_ready = 1'b0;
        resolve_valid = 1'b0;
        resolve_taken = 1'b0;
        resolve_pc = '0;
        resolve_target = '0;
        resolve_pred_next = '0;
        for (int i = 0; i < fetch_pkg::TABLE_SIZE; i++) begin
            m_valid[i] = 1'b0;
            m_word[i] = '0;
            m_target[i] = '0;
            m_ctr[i] = fetch_pkg::CTR_WEAK_NT;
        end
        exp_pc = fetch_pkg::RESET_PC;
        exp_count = 16'd0;
        first_taken = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_stream();
        test_stall_stream();
        test_taken_redirect();
        test_matching_resolve();
        test_counter_hysteresis();
        test_slot_alias();
        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Timeout: the tests did not finish within their cycle budget");
    end

endmodule

//--- verilog/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve (
    input  logic             clk,
    input  logic             reset,
    // Resolved branch from execute
    input  logic             resolve_valid,
    input  logic             resolve_taken,
    input  fetch_pkg::addr_t resolve_pc,
    input  fetch_pkg::addr_t resolve_target,
    input  fetch_pkg::addr_t resolve_pred_next,
    // Training toward the predictor table
    output logic             train_valid,
    output logic             train_taken,
    output fetch_pkg::addr_t train_pc,
    output fetch_pkg::addr_t train_target,
    // Redirect toward PC generator and queue
    output logic             redirect_valid,
    output fetch_pkg::addr_t redirect_pc,
    output logic [15:0]      mispredict_count
);

    fetch_pkg::addr_t actual_next;
    logic             mismatch;

    // Where the program really goes after this branch
    assign actual_next = resolve_taken ? resolve_target
                                       : resolve_pc + fetch_pkg::addr_t'(4);

    assign mismatch = resolve_valid && (actual_next != resolve_pred_next);

    // Control pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            train_valid    <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            train_valid    <= resolve_valid;
            redirect_valid <= mismatch;
        end
    end

    // Payload follows the pulses
    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            train_taken  <= resolve_taken;
            train_pc     <= resolve_pc;
            train_target <= resolve_target;
            redirect_pc  <= actual_next;
        end
    end

    // Saturating mispredict counter
    always_ff @(posedge clk) begin
        if (reset) begin
            mispredict_count <= 16'd0;
        end else if (mismatch && (mispredict_count != 16'hffff)) begin
            mispredict_count <= mispredict_count + 16'd1;
        end
    end

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    // Write side
    input  logic push_valid,
    input  T     push_data,
    output logic push_ready,
    // Read side
    output logic pop_valid,
    output T     pop_data,
    input  logic pop_ready
);

    typedef logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(fetch_pkg::QUEUE_DEPTH+1)-1:0] cnt_t;

    T     mem [fetch_pkg::QUEUE_DEPTH];
    ptr_t rd_ptr;
    ptr_t wr_ptr;
    cnt_t count;
    logic push_fire;
    logic pop_fire;

    assign push_ready = (count != cnt_t'(fetch_pkg::QUEUE_DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];

    assign push_fire = push_valid && push_ready && !flush;
    assign pop_fire  = pop_valid && pop_ready && !flush;

    // Pointer wrap at depth
    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == ptr_t'(fetch_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + ptr_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_t'(push_fire) - cnt_t'(pop_fire);
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Occupancy never runs past the depth
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        count <= cnt_t'(fetch_pkg::QUEUE_DEPTH)
    );

    // Head entry held while the consumer stalls
    a_stable_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (pop_valid && !pop_ready && !flush) |=> (pop_valid && $stable(pop_data))
    );

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic             clk,
    input  logic             reset,
    // Fetch stream toward decode
    output logic             fetch_valid,
    input  logic             fetch_ready,
    output fetch_pkg::addr_t fetch_pc,
    output logic             fetch_pred_taken,
    output fetch_pkg::addr_t fetch_pred_next,
    // Resolved branches from execute
    input  logic             resolve_valid,
    input  logic             resolve_taken,
    input  fetch_pkg::addr_t resolve_pc,
    input  fetch_pkg::addr_t resolve_target,
    input  fetch_pkg::addr_t resolve_pred_next,
    output logic [15:0]      mispredict_count
);

    fetch_pkg::addr_t        lookup_pc;
    logic                    pred_taken;
    fetch_pkg::addr_t        pred_target;
    logic                    push_valid;
    logic                    push_ready;
    fetch_pkg::fetch_entry_t push_entry;
    fetch_pkg::fetch_entry_t pop_entry;
    logic                    train_valid;
    logic                    train_taken;
    fetch_pkg::addr_t        train_pc;
    fetch_pkg::addr_t        train_target;
    logic                    redirect_valid;
    fetch_pkg::addr_t        redirect_pc;

    // Hit alone is not needed, taken already includes it
    bpred_table u_bpred_table (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (lookup_pc),
        .pred_hit     (),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .train_valid  (train_valid),
        .train_taken  (train_taken),
        .train_pc     (train_pc),
        .train_target (train_target)
    );

    pc_gen u_pc_gen (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .lookup_pc      (lookup_pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .push_valid     (push_valid),
        .push_entry     (push_entry),
        .push_ready     (push_ready)
    );

    // Redirect also flushes wrong-path entries
    fetch_queue #(
        .T (fetch_pkg::fetch_entry_t)
    ) u_fetch_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (redirect_valid),
        .push_valid (push_valid),
        .push_data  (push_entry),
        .push_ready (push_ready),
        .pop_valid  (fetch_valid),
        .pop_data   (pop_entry),
        .pop_ready  (fetch_ready)
    );

    branch_resolve u_branch_resolve (
        .clk               (clk),
        .reset             (reset),
        .resolve_valid     (resolve_valid),
        .resolve_taken     (resolve_taken),
        .resolve_pc        (resolve_pc),
        .resolve_target    (resolve_target),
        .resolve_pred_next (resolve_pred_next),
        .train_valid       (train_valid),
        .train_taken       (train_taken),
        .train_pc          (train_pc),
        .train_target      (train_target),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc),
        .mispredict_count  (mispredict_count)
    );

    assign fetch_pc         = pop_entry.pc;
    assign fetch_pred_taken = pop_entry.pred_taken;
    assign fetch_pred_next  = pop_entry.pred_next;

endmodule

//--- verilog/pc_gen.sv
`timescale 1ns/1ns

module pc_gen (
    input  logic                    clk,
    input  logic                    reset,
    // Redirect from branch resolution
    input  logic                    redirect_valid,
    input  fetch_pkg::addr_t        redirect_pc,
    // Predictor lookup
    output fetch_pkg::addr_t        lookup_pc,
    input  logic                    pred_taken,
    input  fetch_pkg::addr_t        pred_target,
    // Push into the fetch queue
    output logic                    push_valid,
    output fetch_pkg::fetch_entry_t push_entry,
    input  logic                    push_ready
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t pred_next;
    logic             push_fire;

    assign lookup_pc = pc;

    // Follow the predictor, otherwise fall through
    assign pred_next = pred_taken ? pred_target : pc + fetch_pkg::addr_t'(4);

    // Redirect cycle carries a stale PC, so hold the push back
    assign push_valid = !redirect_valid;
    assign push_fire  = push_valid && push_ready;

    always_comb begin
        push_entry.pc         = pc;
        push_entry.pred_taken = pred_taken;
        push_entry.pred_next  = pred_next;
    end

    // Fetch PC register, redirect wins
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= fetch_pkg::RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (push_fire) begin
            pc <= pred_next;
        end
    end

    // No entry enters the queue alongside a redirect
    a_no_push_on_redirect: assert property (
        @(posedge clk) disable iff (reset)
        redirect_valid |-> !push_valid
    );

endmodule

//--- vlog.f
common/fetch_pkg.sv
bpred/bpred_table.sv
verilog/pc_gen.sv
verilog/fetch_queue.sv
verilog/branch_resolve.sv
verilog/fetch_top.sv
dv/fetch_tb.sv
